//--- Makefile
TOP := icache_subsystem_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) \
		-f flist.f -Mdir obj_dir -o sim
	./obj_dir/sim | tee $(LOG)
	@grep -q "Verification passed" $(LOG) && echo "TEST PASSED" || \
		(echo "TEST FAILED"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

//--- flist.f
+incdir+logic
logic/mem_if_pkg.sv
logic/icache_pkg.sv
logic/miss_requester.sv
logic/icache_mshr.sv
logic/icache_store.sv
logic/icache_subsystem.sv
testbench/icache_subsystem_assertions.sv
testbench/icache_subsystem_tb.sv

//--- logic/icache_macros.svh
`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

// Cache geometry
`define ICACHE_LINES       8
`define ITAG_BITS          13
`define BLOCK_OFFSET_BITS  3

// Memory block width in bits
`define MEM_BLOCK_BITS     64

// Tags 1 to 15 are live, tag 0 marks an idle response
`define NUM_MEM_TAGS       15
`define MEM_TAG_BITS       ($clog2(`NUM_MEM_TAGS + 1))

// One MSHR slot per memory tag plus one spare
`define MSHR_DEPTH         (`NUM_MEM_TAGS + 1)

// Must be nonzero for the victim LFSR
`define LFSR_SEED          5

`endif

//--- logic/icache_mshr.sv
`include "icache_macros.svh"

module icache_mshr
    import mem_if_pkg::*;
    import icache_pkg::*;
(
    input  logic        clock,
    input  logic        reset,

    // Lookup from the requester
    input  i_tag_t      i_snoop_tag,
    output logic        o_found,

    // New outstanding miss
    input  mshr_entry_t i_push,

    // Response side
    input  mem_tag_t    i_resp_tag,
    output fill_t       o_fill
);

    mshr_entry_t [`MSHR_DEPTH-1:0] entries;
    mshr_entry_t [`MSHR_DEPTH-1:0] next_entries;
    mshr_ptr_t                     head;
    mshr_ptr_t                     tail;
    mshr_ptr_t                     next_head;
    mshr_ptr_t                     next_tail;
    logic [`MSHR_DEPTH-1:0]        snoop_match;
    logic                          pop;

    // Any live entry for the same block
    always_comb begin
        for (int i = 0; i < `MSHR_DEPTH; i++) begin
            snoop_match[i] = entries[i].valid && (entries[i].i_tag == i_snoop_tag);
        end
    end

    assign o_found = |snoop_match;

    // Responses come back in order, so only the head can match
    assign pop = (i_resp_tag != '0)
              && entries[head].valid
              && (entries[head].mem_tag == i_resp_tag);

    always_comb begin
        o_fill.valid = pop;
        o_fill.tag   = entries[head].i_tag;
    end

    always_comb begin
        next_entries = entries;
        next_head    = head;
        next_tail    = tail;

        if (pop) begin
            next_entries[head].valid = 1'b0;
            next_head                = mshr_ptr_t'(head + 1'b1);
        end

        // Pop first, so a full FIFO can take a push into the freed slot
        if (i_push.valid) begin
            next_entries[tail] = i_push;
            next_tail          = mshr_ptr_t'(tail + 1'b1);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head <= '0;
            tail <= '0;
            for (int i = 0; i < `MSHR_DEPTH; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else begin
            head    <= next_head;
            tail    <= next_tail;
            entries <= next_entries;
        end
    end

endmodule

//--- logic/icache_pkg.sv
`include "icache_macros.svh"

package icache_pkg;

    import mem_if_pkg::*;

    typedef logic [`ITAG_BITS-1:0] i_tag_t;

    // Fetch address split into block tag and byte offset
    typedef struct packed {
        i_tag_t                         tag;
        logic [`BLOCK_OFFSET_BITS-1:0]  offset;
    } i_addr_t;

    typedef struct packed {
        logic    valid;
        i_addr_t addr;
    } fetch_req_t;

    // Data is zero on a miss
    typedef struct packed {
        logic       hit;
        mem_block_t data;
    } fetch_resp_t;

    typedef struct packed {
        logic       valid;
        i_tag_t     tag;
        mem_block_t data;
    } cache_line_t;

    // Fill request from the MSHR, data comes from the response bus
    typedef struct packed {
        logic   valid;
        i_tag_t tag;
    } fill_t;

    typedef struct packed {
        logic     valid;
        mem_tag_t mem_tag;
        i_tag_t   i_tag;
    } mshr_entry_t;

    typedef logic [$clog2(`ICACHE_LINES)-1:0] line_idx_t;
    typedef logic [$clog2(`MSHR_DEPTH)-1:0]   mshr_ptr_t;

endpackage

//--- logic/icache_store.sv
`include "icache_macros.svh"

module icache_store
    import mem_if_pkg::*;
    import icache_pkg::*;
(
    input  logic              clock,
    input  logic              reset,

    // Fetch lookup, two slots
    input  fetch_req_t [1:0]  i_fetch_req,
    output fetch_resp_t [1:0] o_fetch_resp,
    output logic [1:0]        o_hit,

    // Fill from the MSHR head
    input  fill_t             i_fill,
    input  mem_block_t        i_fill_data
);

    cache_line_t [`ICACHE_LINES-1:0]  lines;
    logic [1:0][`ICACHE_LINES-1:0]    match;
    logic                             has_free;
    line_idx_t                        free_idx;
    line_idx_t                        lfsr;
    line_idx_t                        victim_idx;

    // Fully associative compare on both ports
    always_comb begin
        for (int j = 0; j < 2; j++) begin
            o_fetch_resp[j].data = '0;
            for (int i = 0; i < `ICACHE_LINES; i++) begin
                match[j][i] = i_fetch_req[j].valid
                           && lines[i].valid
                           && (lines[i].tag == i_fetch_req[j].addr.tag);
                // At most one line matches, so OR-ing is a mux
                if (match[j][i]) begin
                    o_fetch_resp[j].data = o_fetch_resp[j].data | lines[i].data;
                end
            end
            o_fetch_resp[j].hit = |match[j];
        end
    end

    always_comb begin
        for (int j = 0; j < 2; j++) begin
            o_hit[j] = o_fetch_resp[j].hit;
        end
    end

    // Lowest numbered invalid line
    always_comb begin
        has_free = 1'b0;
        free_idx = '0;
        for (int i = `ICACHE_LINES - 1; i >= 0; i--) begin
            if (!lines[i].valid) begin
                has_free = 1'b1;
                free_idx = line_idx_t'(i);
            end
        end
    end

    // x^3 + x^2 + 1, runs through all seven nonzero states
    always_ff @(posedge clock) begin
        if (reset) begin
            lfsr <= line_idx_t'(`LFSR_SEED);
        end else begin
            lfsr <= {lfsr[1:0], lfsr[2] ^ lfsr[1]};
        end
    end

    assign victim_idx = has_free ? free_idx : lfsr;

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `ICACHE_LINES; i++) begin
                lines[i].valid <= 1'b0;
            end
        end else if (i_fill.valid) begin
            lines[victim_idx].valid <= 1'b1;
            lines[victim_idx].tag   <= i_fill.tag;
            lines[victim_idx].data  <= i_fill_data;
        end
    end

endmodule

//--- logic/icache_subsystem.sv
module icache_subsystem
    import mem_if_pkg::*;
    import icache_pkg::*;
(
    input  logic              clock,
    input  logic              reset,

    // Fetch stage, slot 0 is older
    input  fetch_req_t [1:0]  i_fetch_req,
    output fetch_resp_t [1:0] o_fetch_resp,

    // Memory side
    output mem_req_t          o_mem_req,
    input  logic              i_mem_req_accepted,
    input  mem_tag_t          i_mem_req_tag,
    input  mem_resp_t         i_mem_resp
);

    logic [1:0]  hit;
    i_tag_t      snoop_tag;
    logic        mshr_found;
    mshr_entry_t mshr_push;
    fill_t       fill;

    miss_requester u_miss_requester (
        .clock              (clock),
        .reset              (reset),
        .i_fetch_req        (i_fetch_req),
        .i_hit              (hit),
        .i_mshr_found       (mshr_found),
        .i_mem_req_accepted (i_mem_req_accepted),
        .i_mem_req_tag      (i_mem_req_tag),
        .o_snoop_tag        (snoop_tag),
        .o_mem_req          (o_mem_req),
        .o_mshr_push        (mshr_push)
    );

    icache_mshr u_icache_mshr (
        .clock       (clock),
        .reset       (reset),
        .i_snoop_tag (snoop_tag),
        .o_found     (mshr_found),
        .i_push      (mshr_push),
        .i_resp_tag  (i_mem_resp.tag),
        .o_fill      (fill)
    );

    icache_store u_icache_store (
        .clock        (clock),
        .reset        (reset),
        .i_fetch_req  (i_fetch_req),
        .o_fetch_resp (o_fetch_resp),
        .o_hit        (hit),
        .i_fill       (fill),
        .i_fill_data  (i_mem_resp.data)
    );

endmodule

//--- logic/mem_if_pkg.sv
`include "icache_macros.svh"

package mem_if_pkg;

    // Tag handed out by memory, zero means none
    typedef logic [`MEM_TAG_BITS-1:0] mem_tag_t;

    // One cache block of instruction data
    typedef logic [`MEM_BLOCK_BITS-1:0] mem_block_t;

    // Block address toward memory, offset bits are zero
    typedef struct packed {
        logic                                     valid;
        logic [`ITAG_BITS+`BLOCK_OFFSET_BITS-1:0] addr;
    } mem_req_t;

    // Data returned for an earlier request
    typedef struct packed {
        mem_tag_t   tag;
        mem_block_t data;
    } mem_resp_t;

endpackage

//--- logic/miss_requester.sv
`include "icache_macros.svh"

module miss_requester
    import mem_if_pkg::*;
    import icache_pkg::*;
(
    input  logic             clock,
    input  logic             reset,
    input  fetch_req_t [1:0] i_fetch_req,
    input  logic [1:0]       i_hit,
    input  logic             i_mshr_found,
    input  logic             i_mem_req_accepted,
    input  mem_tag_t         i_mem_req_tag,
    output i_tag_t           o_snoop_tag,
    output mem_req_t         o_mem_req,
    output mshr_entry_t      o_mshr_push
);

    logic   miss_valid;
    i_tag_t miss_tag;
    logic   duplicate;
    logic   accept;
    logic   last_valid;
    i_tag_t last_tag;
    logic   pending;

    // Slot 0 is the older instruction and wins
    always_comb begin
        miss_valid = 1'b0;
        miss_tag   = i_fetch_req[1].addr.tag;
        if (i_fetch_req[0].valid && !i_hit[0]) begin
            miss_valid = 1'b1;
            miss_tag   = i_fetch_req[0].addr.tag;
        end else if (i_fetch_req[1].valid && !i_hit[1]) begin
            miss_valid = 1'b1;
        end
    end

    assign o_snoop_tag = miss_tag;

    // Already in the MSHR, or accepted last cycle and not yet recorded
    assign duplicate = i_mshr_found || (last_valid && (last_tag == miss_tag));

    always_comb begin
        o_mem_req.valid = miss_valid && !duplicate;
        o_mem_req.addr  = {miss_tag, {`BLOCK_OFFSET_BITS{1'b0}}};
    end

    assign accept = o_mem_req.valid && i_mem_req_accepted;

    always_ff @(posedge clock) begin
        if (reset) begin
            last_valid <= 1'b0;
            pending    <= 1'b0;
        end else begin
            pending <= accept;
            if (accept) begin
                last_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            last_tag <= miss_tag;
        end
    end

    // Memory tag shows up one cycle after the accept
    always_comb begin
        o_mshr_push.valid   = pending;
        o_mshr_push.mem_tag = i_mem_req_tag;
        o_mshr_push.i_tag   = last_tag;
    end

endmodule

//--- testbench/icache_subsystem_assertions.sv
`include "icache_macros.svh"

module icache_subsystem_assertions
    import mem_if_pkg::*;
    import icache_pkg::*;
(
    input logic        clock,
    input logic        reset,
    input mshr_entry_t mshr_push,
    input fill_t       fill,
    input mem_req_t    mem_req,
    input logic        mem_req_accepted
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [$clog2(`MSHR_DEPTH):0] occupancy;
    logic                         last_valid;
    mem_req_t                     last_req;
    int                           failures = 0;

    // Shadow count of live MSHR entries
    always_ff @(posedge clock) begin
        if (reset) begin
            occupancy  <= '0;
            last_valid <= 1'b0;
        end else begin
            occupancy <= occupancy + mshr_push.valid - fill.valid;
            if (mem_req.valid && mem_req_accepted) begin
                last_valid <= 1'b1;
                last_req   <= mem_req;
            end
        end
    end

    a_no_push_when_full: assert property (@(posedge clock) disable iff (reset)
        (mshr_push.valid && !fill.valid) |-> (occupancy < `MSHR_DEPTH))
        else begin
            $error("MSHR push while full");
            failures++;
        end

    a_req_held: assert property (@(posedge clock) disable iff (reset)
        (mem_req.valid && !mem_req_accepted) |=> $stable(mem_req))
        else begin
            $error("Memory request changed while waiting for accept");
            failures++;
        end

    a_no_repeat: assert property (@(posedge clock) disable iff (reset)
        (mem_req.valid && mem_req_accepted && last_valid) |-> (mem_req.addr != last_req.addr))
        else begin
            $error("Two consecutive accepted requests for the same block");
            failures++;
        end

endmodule

bind icache_subsystem icache_subsystem_assertions u_icache_subsystem_assertions (
    .clock            (clock),
    .reset            (reset),
    .mshr_push        (mshr_push),
    .fill             (fill),
    .mem_req          (o_mem_req),
    .mem_req_accepted (i_mem_req_accepted)
);

//--- testbench/icache_subsystem_tb.sv
`include "icache_macros.svh"

module icache_subsystem_tb
    import mem_if_pkg::*;
    import icache_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam time CLK_PERIOD = 20ns;
    localparam int  NUM_ROWS   = 16;
    localparam time TIME_LIMIT = NUM_ROWS * 40 * CLK_PERIOD;

    typedef struct {
        i_addr_t a0;
        i_addr_t a1;
        int      pct;
        bit      fresh;
        bit      hit;
    } row_t;

    logic              clock;
    logic              reset;
    fetch_req_t [1:0]  i_fetch_req;
    fetch_resp_t [1:0] o_fetch_resp;
    mem_req_t          o_mem_req;
    logic              i_mem_req_accepted;
    mem_tag_t          i_mem_req_tag;
    mem_resp_t         i_mem_resp;

    row_t     rows [NUM_ROWS];
    int       value_errors;
    int       other_errors;
    int       row_pct;
    int       cycle;
    bit       outstanding [i_tag_t];
    bit       seen [i_tag_t];
    mem_tag_t tag_map [i_tag_t];
    mem_req_t accepted_q [$];
    mem_tag_t resp_tags [$];
    i_tag_t   resp_blks [$];
    int       resp_ready [$];

    icache_subsystem u_icache_subsystem (
        .clock              (clock),
        .reset              (reset),
        .i_fetch_req        (i_fetch_req),
        .o_fetch_resp       (o_fetch_resp),
        .o_mem_req          (o_mem_req),
        .i_mem_req_accepted (i_mem_req_accepted),
        .i_mem_req_tag      (i_mem_req_tag),
        .i_mem_resp         (i_mem_resp)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    // Memory data is the tag widened to 16 bits, inverted and repeated four times
    function automatic mem_block_t block_for_tag(mem_tag_t tag);
        logic [15:0] word;
        word = ~{12'b0, tag};
        return {4{word}};
    endfunction

    task automatic check_fetch_resp(string name, fetch_resp_t exp, fetch_resp_t act);
        if (act !== exp) begin
            value_errors++;
            $display("** Error at %0t: %s expected %h, actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_mem_req(string name, mem_req_t exp, mem_req_t act);
        if (act !== exp) begin
            value_errors++;
            $display("** Error at %0t: %s expected %h, actual %h", $time, name, exp, act);
        end
    endtask

    task automatic fill_table();
        rows[0]  = '{'{13'h040, 3'd2}, '{13'h041, 3'd5}, 100, 1, 0};
        rows[1]  = '{'{13'h042, 3'd0}, '{13'h043, 3'd7}, 20,  1, 0};
        rows[2]  = '{'{13'h044, 3'd1}, '{13'h044, 3'd6}, 60,  1, 0};
        rows[3]  = '{'{13'h045, 3'd3}, '{13'h046, 3'd4}, 100, 1, 0};
        rows[4]  = '{'{13'h047, 3'd0}, '{13'h040, 3'd1}, 50,  1, 0};
        // All eight lines now in use and nothing evicted yet
        rows[5]  = '{'{13'h040, 3'd4}, '{13'h041, 3'd0}, 100, 0, 1};
        rows[6]  = '{'{13'h042, 3'd6}, '{13'h043, 3'd2}, 100, 0, 1};
        rows[7]  = '{'{13'h044, 3'd7}, '{13'h045, 3'd1}, 100, 0, 1};
        rows[8]  = '{'{13'h046, 3'd3}, '{13'h047, 3'd5}, 100, 0, 1};
        rows[9]  = '{'{13'h100, 3'd0}, '{13'h103, 3'd2}, 100, 1, 0};
        rows[10] = '{'{13'h106, 3'd4}, '{13'h109, 3'd6}, 30,  1, 0};
        rows[11] = '{'{13'h10c, 3'd1}, '{13'h10f, 3'd3}, 100, 1, 0};
        rows[12] = '{'{13'h112, 3'd5}, '{13'h115, 3'd7}, 25,  1, 0};
        rows[13] = '{'{13'h118, 3'd2}, '{13'h11b, 3'd0}, 100, 1, 0};
        // Mixed rows where blocks may have been replaced
        rows[14] = '{'{13'h040, 3'd1}, '{13'h100, 3'd4}, 70,  0, 0};
        rows[15] = '{'{13'h106, 3'd3}, '{13'h045, 3'd2}, 100, 0, 0};
    endtask

    task automatic check_hit_data(int slot, i_tag_t blk);
        fetch_resp_t exp;
        if (!tag_map.exists(blk)) begin
            other_errors++;
            $display("Slot %0d hit at %0t on a block that was never requested", slot, $time);
        end else begin
            exp = '{1'b1, block_for_tag(tag_map[blk])};
            check_fetch_resp($sformatf("o_fetch_resp[%0d]", slot), exp, o_fetch_resp[slot]);
        end
    endtask

    // Accepts with the row's probability and answers in order after 1 to 4 cycles
    initial begin : memory_model
        bit       held_valid;
        mem_req_t held_req;
        bit       resp_active;
        i_tag_t   resp_blk;
        mem_tag_t resp_tag;
        mem_tag_t tag_next;
        mem_tag_t next_tag;
        i_tag_t   blk;
        bit       acc_next;
        void'($urandom(5370));
        held_valid  = 0;
        resp_active = 0;
        next_tag    = 1;
        @(negedge reset);
        forever begin
            @(negedge clock);
            cycle++;
            if (held_valid) begin
                check_mem_req("o_mem_req", held_req, o_mem_req);
            end
            held_valid = 0;
            if (resp_active) begin
                outstanding.delete(resp_blk);
            end
            tag_next = '0;
            if (o_mem_req.valid && i_mem_req_accepted) begin
                blk = o_mem_req.addr[`ITAG_BITS+`BLOCK_OFFSET_BITS-1:`BLOCK_OFFSET_BITS];
                if (outstanding.exists(blk)) begin
                    other_errors++;
                    $display("Block %h was requested again at %0t while outstanding", blk, $time);
                end
                outstanding[blk] = 1;
                seen[blk]        = 1;
                tag_map[blk]     = next_tag;
                accepted_q.push_back(o_mem_req);
                resp_tags.push_back(next_tag);
                resp_blks.push_back(blk);
                resp_ready.push_back(cycle + 2 + int'($urandom % 4));
                tag_next = next_tag;
                next_tag = (next_tag == `NUM_MEM_TAGS) ? mem_tag_t'(1) : mem_tag_t'(next_tag + 1);
            end else if (o_mem_req.valid) begin
                held_valid = 1;
                held_req   = o_mem_req;
            end
            resp_active = 0;
            if (resp_tags.size() > 0 && resp_ready[0] <= cycle + 1) begin
                resp_active = 1;
                resp_tag    = resp_tags.pop_front();
                resp_blk    = resp_blks.pop_front();
                void'(resp_ready.pop_front());
            end
            acc_next = ($urandom % 100) < row_pct;
            @(posedge clock);
            #2;
            i_mem_req_accepted = acc_next;
            i_mem_req_tag      = tag_next;
            i_mem_resp.tag     = resp_active ? resp_tag : mem_tag_t'(0);
            i_mem_resp.data    = resp_active ? block_for_tag(resp_tag) : '0;
        end
    end

    initial begin : watchdog
        #(TIME_LIMIT);
        $display("Timeout: the run did not finish within %0t", TIME_LIMIT);
        $display("Verification failed");
        $finish;
    end

    initial begin : stimulus
        bit     order;
        bit     done;
        int     n;
        int     acc_start;
        int     assert_fails;
        i_tag_t b0;
        i_tag_t b1;
        clock              = 0;
        reset              = 1;
        i_fetch_req        = '0;
        i_mem_req_accepted = 0;
        i_mem_req_tag      = '0;
        i_mem_resp         = '0;
        row_pct            = 0;
        cycle              = 0;
        value_errors       = 0;
        other_errors       = 0;
        fill_table();
        repeat (2) @(posedge clock);
        #2;
        reset = 0;

        for (int r = 0; r < NUM_ROWS; r++) begin
            @(posedge clock);
            #2;
            b0 = rows[r].a0.tag;
            b1 = rows[r].a1.tag;
            i_fetch_req[0] = '{1'b1, rows[r].a0};
            i_fetch_req[1] = '{1'b1, rows[r].a1};
            row_pct   = rows[r].pct;
            order     = rows[r].fresh && (b1 != b0) && !seen.exists(b1);
            acc_start = accepted_q.size();
            n         = 0;
            done      = 0;
            while (!done) begin
                @(negedge clock);
                if (n == 0 && rows[r].fresh) begin
                    check_fetch_resp("o_fetch_resp[0]", '0, o_fetch_resp[0]);
                    check_mem_req("o_mem_req", '{1'b1, {b0, 3'b000}}, o_mem_req);
                end
                if (n == 0 && rows[r].hit && !(o_fetch_resp[0].hit && o_fetch_resp[1].hit)) begin
                    other_errors++;
                    $display("Row %0d should hit at once but missed at %0t", r, $time);
                end
                if (o_fetch_resp[0].hit) begin
                    check_hit_data(0, b0);
                end
                if (o_fetch_resp[1].hit) begin
                    check_hit_data(1, b1);
                end
                done = o_fetch_resp[0].hit && o_fetch_resp[1].hit;
                n++;
            end
            @(posedge clock);
            if (order) begin
                if (accepted_q.size() < acc_start + 2) begin
                    other_errors++;
                    $display("Row %0d finished with fewer than two requests", r);
                end else begin
                    check_mem_req("accepted o_mem_req", '{1'b1, {b0, 3'b000}},
                                  accepted_q[acc_start]);
                    check_mem_req("accepted o_mem_req", '{1'b1, {b1, 3'b000}},
                                  accepted_q[acc_start + 1]);
                end
            end
        end

        // Every accepted request has to come back as a fill
        while (outstanding.size() > 0 || resp_tags.size() > 0) begin
            @(posedge clock);
        end

        assert_fails = u_icache_subsystem.u_icache_subsystem_assertions.failures;
        $display("Value errors: %0d, other errors: %0d, assertion failures: %0d",
                 value_errors, other_errors, assert_fails);
        if (value_errors == 0 && other_errors == 0 && assert_fails == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
